// ==== jsp_alu.f ====
verilog/alu_isa_pkg.sv
verilog/alu_data_pkg.sv
verilog/alu_control.sv
verilog/alu_datapath.sv
verilog/alu_flags.sv
verilog/alu_stage.sv
test/clock_gen.sv
test/alu_tb.sv

// ==== test/alu_tb.sv ====
`default_nettype none

module alu_tb;

	localparam int TABLE_LEN = 27;
	localparam int RAND_LEN = 64;
	localparam int CYCLE_LIMIT = 10 + TABLE_LEN + RAND_LEN + 20; // Reset, table, random, slack

	// One hand-worked row, flags as {carry, zero, sign}
	typedef struct packed {
		alu_isa_pkg::alu_op_e     op;
		logic [7:0]               a;
		logic [7:0]               b;
		logic [7:0]               value;
		alu_data_pkg::alu_flags_t flags;
	} vector_t;

	wire                      clock;
	wire                      rst_n;
	alu_data_pkg::alu_req_t   req;
	alu_data_pkg::alu_res_t   res;
	logic                     alu_active;

	vector_t                  vectors [TABLE_LEN];
	logic [15:0]              lfsr_state = 16'd75;
	int                       cycles = 0;
	int                       checks = 0;
	int                       errors = 0;
	logic                     pending = 1'b0; // Result due at the next sample
	alu_isa_pkg::alu_op_e     pend_op;
	logic [7:0]               pend_value;
	alu_data_pkg::alu_flags_t pend_flags;
	alu_data_pkg::alu_flags_t model_flags; // Reference copy of the flag register

	clock_gen u_clock_gen (
		.clock (clock),
		.rst_n (rst_n)
	);

	alu_stage DUT (
		.clock      (clock),
		.rst_n      (rst_n),
		.req        (req),
		.res        (res),
		.alu_active (alu_active)
	);

	// 16-bit Galois LFSR, taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // One step per bit
			v = {v[6:0], lfsr_state[0]};
		end
	endtask

	// Opcode semantics, 9-bit result with carry on top
	function automatic logic [8:0] model_sum(input alu_isa_pkg::alu_op_e op,
		input logic [7:0] a, input logic [7:0] b, input logic c);
		case (op)
			alu_isa_pkg::SHL:  model_sum = {a, 1'b0};
			alu_isa_pkg::SHR:  model_sum = {2'b00, a[7:1]};
			alu_isa_pkg::ADD:  model_sum = a + b;
			alu_isa_pkg::ADDC: model_sum = a + b + c;
			alu_isa_pkg::INC:  model_sum = a + 9'd1;
			alu_isa_pkg::INCC: model_sum = a + c;
			alu_isa_pkg::SUB:  model_sum = a + {1'b0, ~b} + 9'd1; // Carry set means no borrow
			alu_isa_pkg::SUBB: model_sum = a + {1'b0, ~b} + c;
			alu_isa_pkg::DEC:  model_sum = a + 9'h0FF;
			alu_isa_pkg::AND:  model_sum = {1'b0, a & b};
			alu_isa_pkg::OR:   model_sum = {1'b0, a | b};
			alu_isa_pkg::XOR:  model_sum = {1'b0, a ^ b};
			alu_isa_pkg::NOT:  model_sum = {1'b0, ~b};
			alu_isa_pkg::CLC:  model_sum = 9'd0;
			default:           model_sum = {1'b0, a}; // NOP and ERR pass A
		endcase
	endfunction

	task automatic load_vectors;
		vectors[0]  = {alu_isa_pkg::ADD,  8'h80, 8'h80, 8'h00, 3'b110}; // Overflow to zero
		vectors[1]  = {alu_isa_pkg::ADDC, 8'h01, 8'h02, 8'h04, 3'b000}; // Uses carry 1
		vectors[2]  = {alu_isa_pkg::ADD,  8'hFF, 8'h01, 8'h00, 3'b110};
		vectors[3]  = {alu_isa_pkg::NOP,  8'h12, 8'h34, 8'h12, 3'b110}; // Flags held
		vectors[4]  = {alu_isa_pkg::ADDC, 8'h10, 8'h20, 8'h31, 3'b000}; // Carry across bubble
		vectors[5]  = {alu_isa_pkg::INC,  8'hFF, 8'h00, 8'h00, 3'b110};
		vectors[6]  = {alu_isa_pkg::INCC, 8'h7F, 8'h00, 8'h80, 3'b001};
		vectors[7]  = {alu_isa_pkg::SUB,  8'h55, 8'h55, 8'h00, 3'b110}; // Equal operands
		vectors[8]  = {alu_isa_pkg::SUB,  8'h10, 8'h20, 8'hF0, 3'b001}; // Borrow
		vectors[9]  = {alu_isa_pkg::SUBB, 8'h30, 8'h10, 8'h1F, 3'b100};
		vectors[10] = {alu_isa_pkg::NOP,  8'h00, 8'h00, 8'h00, 3'b100};
		vectors[11] = {alu_isa_pkg::SUBB, 8'h30, 8'h10, 8'h20, 3'b100};
		vectors[12] = {alu_isa_pkg::DEC,  8'h00, 8'h00, 8'hFF, 3'b001};
		vectors[13] = {alu_isa_pkg::DEC,  8'h01, 8'h00, 8'h00, 3'b110};
		vectors[14] = {alu_isa_pkg::INCC, 8'h05, 8'h00, 8'h06, 3'b000};
		vectors[15] = {alu_isa_pkg::AND,  8'hF0, 8'h3C, 8'h30, 3'b000};
		vectors[16] = {alu_isa_pkg::OR,   8'hF0, 8'h0C, 8'hFC, 3'b001};
		vectors[17] = {alu_isa_pkg::XOR,  8'hFF, 8'h0F, 8'hF0, 3'b001};
		vectors[18] = {alu_isa_pkg::NOT,  8'h00, 8'h5A, 8'hA5, 3'b001};
		vectors[19] = {alu_isa_pkg::SHL,  8'h81, 8'h00, 8'h02, 3'b100}; // a[7] into carry
		vectors[20] = {alu_isa_pkg::SHR,  8'h81, 8'h00, 8'h40, 3'b000};
		vectors[21] = {alu_isa_pkg::SHL,  8'hC0, 8'h00, 8'h80, 3'b101};
		vectors[22] = {alu_isa_pkg::CLC,  8'h77, 8'h88, 8'h00, 3'b010};
		vectors[23] = {alu_isa_pkg::ERR,  8'h9A, 8'h00, 8'h9A, 3'b001}; // A falls through
		vectors[24] = {alu_isa_pkg::ERR,  8'h00, 8'h55, 8'h00, 3'b010};
		vectors[25] = {alu_isa_pkg::NOP,  8'h80, 8'h00, 8'h80, 3'b010};
		vectors[26] = {alu_isa_pkg::SHL,  8'h00, 8'h00, 8'h00, 3'b010};
	endtask

	task automatic compare_result;
		checks++;
		assert (res.value == pend_value) else begin
			errors++;
			$display("[ERROR] %0t op=%s value expected %h got %h",
				$time, pend_op.name(), pend_value, res.value);
		end
		assert (res.flags == pend_flags) else begin
			errors++;
			$display("[ERROR] %0t op=%s flags expected %b got %b",
				$time, pend_op.name(), pend_flags, res.flags);
		end
		assert (alu_active == (pend_op != alu_isa_pkg::NOP)) else begin
			errors++;
			$display("[ERROR] %0t op=%s alu_active expected %b got %b",
				$time, pend_op.name(), pend_op != alu_isa_pkg::NOP, alu_active);
		end
	endtask

	// Drive on the edge, sample the previous request at the falling edge
	task automatic issue(input alu_isa_pkg::alu_op_e op, input logic [7:0] a,
		input logic [7:0] b, input logic [7:0] exp_value,
		input alu_data_pkg::alu_flags_t exp_flags);
		@(posedge clock);
		req <= {op, a, b};
		@(negedge clock);
		if (pending) begin
			compare_result();
		end
		pending    = 1'b1;
		pend_op    = op;
		pend_value = exp_value;
		pend_flags = exp_flags;
	endtask

	task automatic check_reset;
		wait (rst_n === 1'b1);
		@(negedge clock); // Last edge still saw reset
		checks++;
		assert (res.value == 8'h00 && res.flags == 3'b000 && alu_active == 1'b0) else begin
			errors++;
			$display("[ERROR] %0t reset state value %h flags %b alu_active %b",
				$time, res.value, res.flags, alu_active);
		end
	endtask

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run timed out after %0d cycles without finishing the tests", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		alu_isa_pkg::alu_op_e op;
		logic [7:0]           bits;
		logic [7:0]           a;
		logic [7:0]           b;
		logic [8:0]           sum;
		req = {alu_isa_pkg::NOP, 8'h00, 8'h00};
		load_vectors();
		check_reset();
		for (int i = 0; i < TABLE_LEN; i++) begin
			issue(vectors[i].op, vectors[i].a, vectors[i].b, vectors[i].value, vectors[i].flags);
		end
		// Random ops, model picks up the flags the table left
		model_flags = vectors[TABLE_LEN-1].flags;
		for (int n = 0; n < RAND_LEN; n++) begin
			take_bits(4, bits);
			op = alu_isa_pkg::alu_op_e'(bits[3:0]);
			take_bits(8, a);
			take_bits(8, b);
			sum = model_sum(op, a, b, model_flags.carry);
			if (op != alu_isa_pkg::NOP) begin
				model_flags.carry = sum[8];
				model_flags.zero  = (sum[7:0] == 8'h00);
				model_flags.sign  = sum[7];
			end
			issue(op, a, b, sum[7:0], model_flags);
		end
		issue(alu_isa_pkg::NOP, 8'h00, 8'h00, 8'h00, model_flags); // Drains the last result
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/clock_gen.sv ====
`default_nettype none

// Free-running clock of period 4, reset low for the first 10 edges
module clock_gen (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clock);
		rst_n <= 1'b1; // Released on the 10th edge
	end

endmodule

`default_nettype wire

// ==== verilog/alu_control.sv ====
`default_nettype none

// Opcode to control byte lookup
module alu_control (
	input  wire                     clock, // Assertion sampling only
	input  alu_isa_pkg::alu_op_e    op,
	output alu_isa_pkg::ctrl_word_u ctrl,
	output logic                    alu_active
);

	// Byte layout is CS[7:6] LHS[5:4] RHS[3:0]
	always_comb begin
		alu_active = 1'b1; // Every row but NOP wakes the ALU
		case (op)
			alu_isa_pkg::NOP: begin
				ctrl.raw   = 8'h00; // Idle so flags hold
				alu_active = 1'b0;
			end
			alu_isa_pkg::SHL:  ctrl.raw = 8'h10; // Shifted A + 0
			alu_isa_pkg::SHR:  ctrl.raw = 8'h20;
			alu_isa_pkg::ADD:  ctrl.raw = 8'h0C; // A + B
			alu_isa_pkg::ADDC: ctrl.raw = 8'h4C; // A + B + C
			alu_isa_pkg::INC:  ctrl.raw = 8'h80; // A + 0 + 1
			alu_isa_pkg::INCC: ctrl.raw = 8'h40;
			alu_isa_pkg::SUB:  ctrl.raw = 8'h83; // A + ~B + 1
			alu_isa_pkg::SUBB: ctrl.raw = 8'h43; // A + ~B + C
			alu_isa_pkg::DEC:  ctrl.raw = 8'h0F; // A + FF
			alu_isa_pkg::AND:  ctrl.raw = 8'h38; // Zero lhs with table 1000
			alu_isa_pkg::OR:   ctrl.raw = 8'h3E;
			alu_isa_pkg::XOR:  ctrl.raw = 8'h36;
			alu_isa_pkg::NOT:  ctrl.raw = 8'h33; // ~B
			alu_isa_pkg::CLC:  ctrl.raw = 8'h30; // 0 + 0 + 0
			alu_isa_pkg::ERR:  ctrl.raw = 8'h00;
			default:           ctrl.raw = 8'h00;
		endcase
	end

	// ERR and NOP share a control byte so only the opcode tells them apart
	a_active_matches_op: assert property (
		@(posedge clock) alu_active == (op != alu_isa_pkg::NOP)
	) else $error("alu_active disagrees with opcode %s", op.name());

endmodule

`default_nettype wire

// ==== verilog/alu_data_pkg.sv ====
`default_nettype none

package alu_data_pkg;

	localparam int DATA_W = 8; // Operand and result width

	// Flag register contents
	typedef struct packed {
		logic carry; // Bit 8 of the 9-bit sum
		logic zero;  // Result is all zeros
		logic sign;  // Result MSB
	} alu_flags_t;

	// One operation per clock from pipe register
	typedef struct packed {
		alu_isa_pkg::alu_op_e op;
		logic [DATA_W-1:0]    a;
		logic [DATA_W-1:0]    b;
	} alu_req_t;

	// Registered stage output
	typedef struct packed {
		logic [DATA_W-1:0] value;
		alu_flags_t        flags;
	} alu_res_t;

endpackage

`default_nettype wire

// ==== verilog/alu_datapath.sv ====
`default_nettype none

// Combinational ALU core, driven by one control byte
module alu_datapath (
	input  wire                                    clock, // Assertion sampling only
	input  alu_isa_pkg::ctrl_word_u                ctrl,
	input  wire  [alu_data_pkg::DATA_W-1:0]        a,
	input  wire  [alu_data_pkg::DATA_W-1:0]        b,
	input  wire                                    carry_in_flag, // Stored carry
	output logic [alu_data_pkg::DATA_W-1:0]        value,
	output alu_data_pkg::alu_flags_t               flags_next
);

	logic [alu_data_pkg::DATA_W-1:0] rhs; // Truth table output
	logic [alu_data_pkg::DATA_W:0]   lhs; // One extra bit for SHL
	logic [alu_data_pkg::DATA_W:0]   sum;
	logic                            carry_in;

	// Per-bit 4:1 mux, b is the high select
	always_comb begin
		for (int i = 0; i < alu_data_pkg::DATA_W; i++) begin
			rhs[i] = ctrl.fields.rhs_tt[{b[i], a[i]}];
		end
	end

	// Left operand, zero-extended to 9 bits
	always_comb begin
		case (ctrl.fields.lhs_sel)
			alu_isa_pkg::LHS_A:
				lhs = {1'b0, a};
			alu_isa_pkg::LHS_SHL:
				lhs = {a, 1'b0}; // a[7] becomes carry
			alu_isa_pkg::LHS_SHR:
				lhs = {2'b00, a[alu_data_pkg::DATA_W-1:1]}; // Low bit dropped
			alu_isa_pkg::LHS_ZERO:
				lhs = '0;
			default:
				lhs = '0;
		endcase
	end

	// Carry-in mux
	always_comb begin
		case (ctrl.fields.carry_sel)
			alu_isa_pkg::CS_ZERO:     carry_in = 1'b0;
			alu_isa_pkg::CS_FLAG:     carry_in = carry_in_flag; // Chained ops
			alu_isa_pkg::CS_ONE:      carry_in = 1'b1; // INC, SUB
			alu_isa_pkg::CS_ZERO_ALT: carry_in = 1'b0;
			default:                  carry_in = 1'b0;
		endcase
	end

	// Single 9-bit adder does all arithmetic
	assign sum = lhs + {1'b0, rhs} + {{alu_data_pkg::DATA_W{1'b0}}, carry_in};

	assign value = sum[alu_data_pkg::DATA_W-1:0];

	// Next flags, loaded only when the stage is active
	always_comb begin
		flags_next.carry = sum[alu_data_pkg::DATA_W];
		flags_next.zero  = (value == '0);
		flags_next.sign  = value[alu_data_pkg::DATA_W-1]; // MSB of result
	end

	// Logic ops must pass the truth table straight through the adder
	a_logic_passthrough: assert property (
		@(posedge clock)
		(ctrl.fields.lhs_sel == alu_isa_pkg::LHS_ZERO &&
			(ctrl.fields.carry_sel == alu_isa_pkg::CS_ZERO ||
			ctrl.fields.carry_sel == alu_isa_pkg::CS_ZERO_ALT))
		|-> (value == rhs)
	) else $error("logic op value %h differs from rhs %h", value, rhs);

endmodule

`default_nettype wire

// ==== verilog/alu_flags.sv ====
`default_nettype none

// Carry, zero, sign register
// Load enable stands in for the gated ALU clock
module alu_flags (
	input  wire                      clock,
	input  wire                      rst_n,
	input  wire                      alu_active,
	input  alu_data_pkg::alu_flags_t flags_next,
	output alu_data_pkg::alu_flags_t flags
);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (alu_active) begin
			flags <= flags_next; // Only active ops touch flags
		end
	end

	// Bubbles must not disturb carry between chained ops
	a_hold_on_bubble: assert property (
		@(posedge clock) disable iff (!rst_n)
		!alu_active |=> $stable(flags)
	) else $error("flags changed after an idle cycle");

endmodule

`default_nettype wire

// ==== verilog/alu_isa_pkg.sv ====
`default_nettype none

package alu_isa_pkg;

	localparam int OP_W = 4; // Opcode field from pipe stage 1
	localparam int CTRL_W = 8; // One control byte per opcode

	// ALU opcodes as seen by the ALU stage
	typedef enum logic [OP_W-1:0] {
		NOP  = 4'd0, // Bubble, ALU idle
		SHL  = 4'd1,
		SHR  = 4'd2,
		ADD  = 4'd3,
		ADDC = 4'd4, // Add with stored carry
		INC  = 4'd5,
		INCC = 4'd6,
		SUB  = 4'd7,
		SUBB = 4'd8, // Subtract with stored borrow
		DEC  = 4'd9,
		AND  = 4'd10,
		OR   = 4'd11,
		XOR  = 4'd12,
		NOT  = 4'd13,
		CLC  = 4'd14,
		ERR  = 4'd15 // Active, but A falls through
	} alu_op_e;

	// Left operand source
	typedef enum logic [1:0] {
		LHS_A    = 2'd0,
		LHS_SHL  = 2'd1, // A << 1, A[7] lands in bit 8
		LHS_SHR  = 2'd2, // Logical shift
		LHS_ZERO = 2'd3
	} lhs_sel_e;

	// Carry-in source, two codes give zero
	typedef enum logic [1:0] {
		CS_ZERO     = 2'd0,
		CS_FLAG     = 2'd1, // Carry left by last active op
		CS_ONE      = 2'd2,
		CS_ZERO_ALT = 2'd3
	} carry_sel_e;

	typedef struct packed {
		carry_sel_e carry_sel; // Bits 7:6
		lhs_sel_e   lhs_sel;   // Bits 5:4
		logic [3:0] rhs_tt;    // Bits 3:0, indexed by {b, a}
	} ctrl_fields_t;

	// Decoder writes raw, datapath reads fields
	typedef union packed {
		logic [CTRL_W-1:0] raw;
		ctrl_fields_t      fields;
	} ctrl_word_u;

endpackage

`default_nettype wire

// ==== verilog/alu_stage.sv ====
`default_nettype none

// ALU pipeline stage, one request per clock, one cycle latency
module alu_stage (
	input  wire                    clock,
	input  wire                    rst_n,
	input  alu_data_pkg::alu_req_t req,
	output alu_data_pkg::alu_res_t res,
	output logic                   alu_active
);

	alu_isa_pkg::ctrl_word_u         ctrl;
	logic                            active_next; // Decoded, not yet registered
	logic [alu_data_pkg::DATA_W-1:0] value_next;
	logic [alu_data_pkg::DATA_W-1:0] value_q;
	alu_data_pkg::alu_flags_t        flags_next;
	alu_data_pkg::alu_flags_t        flags_q;

	alu_control u_control (
		.clock      (clock),
		.op         (req.op),
		.ctrl       (ctrl),
		.alu_active (active_next)
	);

	// Stored carry feeds back for ADDC, INCC, SUBB
	alu_datapath u_datapath (
		.clock         (clock),
		.ctrl          (ctrl),
		.a             (req.a),
		.b             (req.b),
		.carry_in_flag (flags_q.carry),
		.value         (value_next),
		.flags_next    (flags_next)
	);

	alu_flags u_flags (
		.clock      (clock),
		.rst_n      (rst_n),
		.alu_active (active_next),
		.flags_next (flags_next),
		.flags      (flags_q)
	);

	// Output register, same edge as the flag load
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			value_q    <= '0;
			alu_active <= 1'b0;
		end else begin
			value_q    <= value_next; // Bubbles still update value
			alu_active <= active_next;
		end
	end

	assign res.value = value_q;
	assign res.flags = flags_q; // Already one cycle behind, lines up with value_q

endmodule

`default_nettype wire
